// File: build.f
+incdir+logic
logic/usb_in_pkg.sv
logic/axis_byte_if.sv
logic/telemetry_capture.sv
logic/in_source_select.sv
logic/axis_skid.sv
logic/usb_in_path.sv
verification/tb_clock_gen.sv
verification/usb_in_path_tb.sv

// File: logic/axis_byte_if.sv
`timescale 1ns/1ps
`include "usb_in_macros.svh"

// byte-wide AXI4-stream link
interface axis_byte_if;

  logic                   tvalid;
  logic                   tready;
  logic                   tlast;
  logic                   tkeep;
  logic [`USB_BYTE_W-1:0] tdata;

  modport source (
    output tvalid, tlast, tkeep, tdata,
    input  tready
  );

  modport sink (
    input  tvalid, tlast, tkeep, tdata,
    output tready
  );

endinterface

// File: logic/axis_skid.sv
`timescale 1ns/1ps
`include "usb_in_macros.svh"

module axis_skid (
  input  logic                   clock,
  input  logic                   areset_n,
  input  logic                   m_axis_tready_i,
  output logic                   m_axis_tvalid_o,
  output logic                   m_axis_tlast_o,
  output logic                   m_axis_tkeep_o,
  output logic [`USB_BYTE_W-1:0] m_axis_tdata_o,
  axis_byte_if.sink              sel_stream
);

  localparam int unsigned ENTRY_W = `USB_BYTE_W + 2;  // last, keep, data

  logic [ENTRY_W-1:0] in_w;
  logic [ENTRY_W-1:0] out_q;   // output entry
  logic [ENTRY_W-1:0] skid_q;  // overflow entry
  logic               out_valid_q;
  logic               skid_valid_q;
  logic               in_fire_w;
  logic               out_fire_w;
  logic               load_from_skid_w;
  logic               load_from_in_w;
  logic               load_skid_w;

  assign in_w       = {sel_stream.tlast, sel_stream.tkeep, sel_stream.tdata};
  assign in_fire_w  = sel_stream.tvalid & sel_stream.tready;
  assign out_fire_w = out_valid_q & m_axis_tready_i;

  // skid entry drains first, keeping byte order
  assign load_from_skid_w = skid_valid_q & out_fire_w;
  assign load_from_in_w   = in_fire_w & (~out_valid_q | out_fire_w);
  assign load_skid_w      = in_fire_w & out_valid_q & ~out_fire_w;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (load_from_skid_w) begin
        skid_valid_q <= 1'b0;
      end else if (load_skid_w) begin
        skid_valid_q <= 1'b1;  // output stalled, park the byte
      end

      if (load_from_in_w || load_from_skid_w) begin
        out_valid_q <= 1'b1;
      end else if (out_fire_w) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load_from_skid_w) begin
      out_q <= skid_q;
    end else if (load_from_in_w) begin
      out_q <= in_w;
    end
    if (load_skid_w) begin
      skid_q <= in_w;
    end
  end

  // ready straight from a flop, low only with both entries full
  assign sel_stream.tready = ~skid_valid_q;

  assign m_axis_tvalid_o = out_valid_q;
  assign {m_axis_tlast_o, m_axis_tkeep_o, m_axis_tdata_o} = out_q;

  a_out_hold: assert property (@(posedge clock) disable iff (!areset_n)
    m_axis_tvalid_o && !m_axis_tready_i |=>
      m_axis_tvalid_o && $stable(out_q));

  // skid only fills behind a full output entry, so at most two held
  a_two_max: assert property (@(posedge clock) disable iff (!areset_n)
    skid_valid_q |-> out_valid_q);

endmodule

// File: logic/in_source_select.sv
`timescale 1ns/1ps
`include "usb_in_macros.svh"

module in_source_select (
  input  logic                     clock,
  input  logic                     areset_n,
  input  logic [`USB_ENDPT_W-1:0]  blk_endpt_i,
  input  logic                     blk_in_ready_i,
  input  logic [`TELE_LEVEL_W-1:0] tele_level_i,
  input  logic                     s_axis_tvalid_i,
  input  logic                     s_axis_tlast_i,
  input  logic                     s_axis_tkeep_i,
  input  logic [`USB_BYTE_W-1:0]   s_axis_tdata_i,
  output logic                     s_axis_tready_o,
  output logic                     blk_in_ready_o,
  axis_byte_if.sink                tele_stream,
  axis_byte_if.source              sel_stream
);

  localparam logic [`USB_ENDPT_W-1:0] TELE_EP = `TELE_ENDPOINT;
  localparam logic [`TELE_LEVEL_W-1:0] READY_L = `TELE_READY_LEVEL;

  logic tele_sel_q;   // host is reading the telemetry endpoint
  logic blk_ready_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      tele_sel_q  <= 1'b0;
      blk_ready_q <= 1'b0;
    end else begin
      tele_sel_q  <= blk_endpt_i == TELE_EP;
      // stretch ready so a filling log gets drained
      blk_ready_q <= blk_in_ready_i || (tele_level_i >= READY_L);
    end
  end

  assign blk_in_ready_o = blk_ready_q;

  // 2:1 stream mux
  assign sel_stream.tvalid = tele_sel_q ? tele_stream.tvalid : s_axis_tvalid_i;
  assign sel_stream.tlast  = tele_sel_q ? tele_stream.tlast : s_axis_tlast_i;
  assign sel_stream.tkeep  = tele_sel_q ? tele_stream.tkeep : s_axis_tkeep_i;
  assign sel_stream.tdata  = tele_sel_q ? tele_stream.tdata : s_axis_tdata_i;

  // only the chosen source sees ready
  assign tele_stream.tready = tele_sel_q & sel_stream.tready;
  assign s_axis_tready_o    = ~tele_sel_q & sel_stream.tready;

  // user byte stays on offer until it is taken
  a_user_hold: assert property (@(posedge clock) disable iff (!areset_n)
    s_axis_tvalid_i && !s_axis_tready_o |=>
      s_axis_tvalid_i && $stable(s_axis_tdata_i) && $stable(s_axis_tlast_i));

endmodule

// File: logic/telemetry_capture.sv
`timescale 1ns/1ps
`include "usb_in_macros.svh"

module telemetry_capture (
  input  logic                     clock,
  input  logic                     areset_n,
  input  logic [3:0]               usb_state_i,
  input  logic [3:0]               ctl_state_i,
  input  logic [6:0]               blk_state_i,
  input  logic                     crc_error_i,
  output logic                     has_telemetry_o,
  output logic [`TELE_LEVEL_W-1:0] tele_level_o,
  axis_byte_if.source              tele_stream
);

  localparam int unsigned PTR_W = $clog2(`TELE_DEPTH);
  localparam int unsigned PKT_W = $clog2(`TELE_PKT_RECORDS);
  localparam logic [`TELE_LEVEL_W-1:0] DEPTH_L = `TELE_DEPTH;
  localparam logic [`TELE_LEVEL_W-1:0] HAS_L = `TELE_HAS_LEVEL;
  localparam logic [`TELE_LEVEL_W-1:0] ONE_L = 1;
  localparam logic [PKT_W-1:0] PKT_LAST = PKT_W'(`TELE_PKT_RECORDS - 1);

  usb_in_pkg::tele_rec_t  live_rec;
  usb_in_pkg::tele_rec_t  last_rec_q;  // last record seen
  usb_in_pkg::tele_word_u mem [`TELE_DEPTH];
  usb_in_pkg::tele_word_u head_w;

  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [`TELE_LEVEL_W-1:0] level_q;
  logic [PKT_W-1:0]         pkt_cnt_q;  // records sent in current packet
  logic                     tvalid_q;
  logic                     byte_hi_q;  // high byte of head on offer
  logic                     tlast_q;
  logic                     full_w;
  logic                     changed_w;
  logic                     push_w;
  logic                     xfer_w;
  logic                     pop_w;

  always_comb begin
    live_rec.usb_state = usb_state_i;
    live_rec.ctl_state = ctl_state_i;
    live_rec.blk_state = blk_state_i;
    live_rec.crc_error = crc_error_i;
  end

  assign full_w    = level_q == DEPTH_L;
  assign changed_w = live_rec != last_rec_q;
  assign push_w    = changed_w & ~full_w;  // dropped when full
  assign xfer_w    = tvalid_q & tele_stream.tready;
  assign pop_w     = xfer_w & byte_hi_q;

  // record storage
  always_ff @(posedge clock) begin
    if (push_w) begin
      mem[wr_ptr_q].rec <= live_rec;
    end
  end

  assign head_w = mem[rd_ptr_q];

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      last_rec_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      pkt_cnt_q  <= '0;
      tvalid_q   <= 1'b0;
      byte_hi_q  <= 1'b0;
      tlast_q    <= 1'b0;
    end else begin
      // track every change, so one that hits a full FIFO is lost
      if (changed_w) begin
        last_rec_q <= live_rec;
      end
      if (push_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_w) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_w, pop_w})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase

      if (!tvalid_q) begin
        if (level_q != '0) begin
          tvalid_q  <= 1'b1;  // low byte goes first
          byte_hi_q <= 1'b0;
        end
      end else if (xfer_w) begin
        if (!byte_hi_q) begin
          byte_hi_q <= 1'b1;
          // decided here so tlast holds steady on the high byte
          tlast_q   <= (pkt_cnt_q == PKT_LAST) || (level_q == ONE_L && !push_w);
        end else begin
          byte_hi_q <= 1'b0;
          tvalid_q  <= level_q > ONE_L;  // next record already waiting
          pkt_cnt_q <= tlast_q ? '0 : pkt_cnt_q + 1'b1;
        end
      end
    end
  end

  assign tele_stream.tvalid = tvalid_q;
  assign tele_stream.tdata  = head_w.bytes[byte_hi_q];
  assign tele_stream.tlast  = byte_hi_q & tlast_q;
  assign tele_stream.tkeep  = 1'b1;

  assign tele_level_o    = level_q;
  assign has_telemetry_o = level_q >= HAS_L;

  // FIFO never overfills, and the readout only pops a stored record
  a_level_bound: assert property (@(posedge clock) disable iff (!areset_n)
    level_q <= DEPTH_L);
  a_pop_nonempty: assert property (@(posedge clock) disable iff (!areset_n)
    pop_w |-> level_q != '0);

  a_tele_hold: assert property (@(posedge clock) disable iff (!areset_n)
    tele_stream.tvalid && !tele_stream.tready |=>
      tele_stream.tvalid && $stable(tele_stream.tdata) && $stable(tele_stream.tlast));

endmodule

// File: logic/usb_in_macros.svh
`ifndef USB_IN_MACROS_SVH
`define USB_IN_MACROS_SVH

// stream and endpoint widths
`define USB_BYTE_W 8
`define USB_ENDPT_W 4

// endpoint that reads back the telemetry log
`define TELE_ENDPOINT 2

// telemetry FIFO, counted in records
`define TELE_DEPTH 16
`define TELE_LEVEL_W 5

// level thresholds
`define TELE_HAS_LEVEL 2
`define TELE_READY_LEVEL 4

// records per telemetry packet before tlast is forced
`define TELE_PKT_RECORDS 8

`endif

// File: logic/usb_in_path.sv
`timescale 1ns/1ps
`include "usb_in_macros.svh"

module usb_in_path (
  input  logic                    clock,
  input  logic                    areset_n,

  // state words from the transactor
  input  logic [3:0]              usb_state_i,
  input  logic [3:0]              ctl_state_i,
  input  logic [6:0]              blk_state_i,
  input  logic                    crc_error_i,

  // bulk endpoint control
  input  logic [`USB_ENDPT_W-1:0] blk_endpt_i,
  input  logic                    blk_in_ready_i,
  output logic                    blk_in_ready_o,
  output logic                    has_telemetry_o,

  // user byte stream in
  input  logic                    s_axis_tvalid_i,
  output logic                    s_axis_tready_o,
  input  logic                    s_axis_tlast_i,
  input  logic                    s_axis_tkeep_i,
  input  logic [`USB_BYTE_W-1:0]  s_axis_tdata_i,

  // bulk IN stream out
  output logic                    m_axis_tvalid_o,
  input  logic                    m_axis_tready_i,
  output logic                    m_axis_tlast_o,
  output logic                    m_axis_tkeep_o,
  output logic [`USB_BYTE_W-1:0]  m_axis_tdata_o
);

  logic [`TELE_LEVEL_W-1:0] tele_level_w;

  axis_byte_if tele_stream ();
  axis_byte_if sel_stream ();

  telemetry_capture u_telemetry_capture (
    .clock           (clock),
    .areset_n        (areset_n),
    .usb_state_i     (usb_state_i),
    .ctl_state_i     (ctl_state_i),
    .blk_state_i     (blk_state_i),
    .crc_error_i     (crc_error_i),
    .has_telemetry_o (has_telemetry_o),
    .tele_level_o    (tele_level_w),
    .tele_stream     (tele_stream.source)
  );

  in_source_select u_in_source_select (
    .clock           (clock),
    .areset_n        (areset_n),
    .blk_endpt_i     (blk_endpt_i),
    .blk_in_ready_i  (blk_in_ready_i),
    .tele_level_i    (tele_level_w),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tkeep_i  (s_axis_tkeep_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tready_o (s_axis_tready_o),
    .blk_in_ready_o  (blk_in_ready_o),
    .tele_stream     (tele_stream.sink),
    .sel_stream      (sel_stream.source)
  );

  axis_skid u_axis_skid (
    .clock           (clock),
    .areset_n        (areset_n),
    .m_axis_tready_i (m_axis_tready_i),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tkeep_o  (m_axis_tkeep_o),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .sel_stream      (sel_stream.sink)
  );

endmodule

// File: logic/usb_in_pkg.sv
`include "usb_in_macros.svh"

package usb_in_pkg;

  // one telemetry record, crc flag in bit 0
  typedef struct packed {
    logic [3:0] usb_state;
    logic [3:0] ctl_state;
    logic [6:0] blk_state;
    logic       crc_error;
  } tele_rec_t;

  // same 16 bits, seen either as fields or as bytes
  // bytes[0] is the low byte, sent first
  typedef union packed {
    tele_rec_t                         rec;
    logic [1:0][`USB_BYTE_W-1:0]       bytes;
  } tele_word_u;

endpackage

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f build.f \
    --top-module usb_in_path_tb -Mdir obj_dir &&
  ./obj_dir/Vusb_in_path_tb | tee /dev/stderr | grep -x "Testbench passed" > /dev/null &&
  echo "simulation run: ok" ||
  { echo "simulation run: not ok"; exit 1; }

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

// free-running clock plus a reset pulse at start
module tb_clock_gen (
  output logic clock_o,
  output logic areset_n_o
);

  localparam int HALF_PERIOD = 4;  // 8 ns period
  localparam int RESET_CYCLES = 3;

  initial begin
    clock_o = 1'b0;
    forever #(HALF_PERIOD) clock_o = ~clock_o;
  end

  initial begin
    areset_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    #1 areset_n_o = 1'b1;  // release clear of the edge
  end

endmodule

// File: verification/usb_in_path_tb.sv
`timescale 1ns/1ps
`include "usb_in_macros.svh"

module usb_in_path_tb;

  localparam int NUM_ROWS = 7;
  localparam int DRAIN_LIMIT = 2000;
  localparam logic [`USB_ENDPT_W-1:0] TELE_EP = `TELE_ENDPOINT;

  typedef struct {
    logic [3:0]  ep;
    logic [15:0] base;    // first record
    logic [15:0] step;    // per-record increment
    int          nrec;
    int          nbytes;  // user bytes
    bit          stall;   // random m_axis back-pressure
    bit          rdy;     // blk_in_ready_i level
  } row_t;

  logic clock;
  logic areset_n;
  logic [3:0] usb_state_i;
  logic [3:0] ctl_state_i;
  logic [6:0] blk_state_i;
  logic crc_error_i;
  logic [`USB_ENDPT_W-1:0] blk_endpt_i;
  logic blk_in_ready_i;
  logic blk_in_ready_o;
  logic has_telemetry_o;
  logic s_axis_tvalid_i;
  logic s_axis_tready_o;
  logic s_axis_tlast_i;
  logic s_axis_tkeep_i;
  logic [`USB_BYTE_W-1:0] s_axis_tdata_i;
  logic m_axis_tvalid_o;
  logic m_axis_tready_i;
  logic m_axis_tlast_o;
  logic m_axis_tkeep_o;
  logic [`USB_BYTE_W-1:0] m_axis_tdata_o;

  row_t table_rows [NUM_ROWS];
  logic [31:0] rng;
  logic [9:0] user_q [$];       // last, keep, data
  logic [9:0] exp_q [$];        // expected on m_axis
  logic [15:0] model_recs [$];  // records the FIFO should hold
  logic [15:0] model_last;
  logic [15:0] rec_next;
  logic [`USB_ENDPT_W-1:0] cur_ep;
  logic cur_rdy;
  logic exp_blk_ready;
  bit rec_pending;
  bit push_pending;
  bit level_known;
  bit in_fire;
  bit stall_en;
  int lvl;
  int ep_age;   // cycles since blk_endpt_i last changed
  int errors;
  int checks;

  tb_clock_gen u_clock_gen (.clock_o(clock), .areset_n_o(areset_n));

  usb_in_path u_usb_in_path (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // drive 1 ns after the edge and observe at the falling edge
  task automatic run_cycle();
    logic [9:0] want;
    @(posedge clock);
    #1;
    if (in_fire) void'(user_q.pop_front());
    exp_blk_ready = blk_in_ready_i || (lvl >= `TELE_READY_LEVEL);  // registered at this edge
    if (push_pending) lvl++;
    push_pending = 1'b0;
    if (blk_endpt_i != cur_ep) begin
      blk_endpt_i = cur_ep;
      ep_age = 0;
    end else begin
      ep_age++;
    end
    blk_in_ready_i = cur_rdy;
    if (rec_pending) begin
      {usb_state_i, ctl_state_i, blk_state_i, crc_error_i} = rec_next;
      if (rec_next != model_last) begin
        model_last = rec_next;  // a change while full is still remembered
        if (model_recs.size() < `TELE_DEPTH) begin
          model_recs.push_back(rec_next);
          push_pending = 1'b1;
        end
      end
      rec_pending = 1'b0;
    end
    s_axis_tvalid_i = user_q.size() > 0;
    if (user_q.size() > 0) {s_axis_tlast_i, s_axis_tkeep_i, s_axis_tdata_i} = user_q[0];
    rng = xorshift32(rng);
    m_axis_tready_i = !stall_en || (rng[1:0] != 2'b00);
    @(negedge clock);
    in_fire = s_axis_tvalid_i && s_axis_tready_o;
    if (level_known) begin
      check_value("has_telemetry_o", 16'(has_telemetry_o), 16'(lvl >= `TELE_HAS_LEVEL));
      check_value("blk_in_ready_o", 16'(blk_in_ready_o), 16'(exp_blk_ready));
    end
    if (cur_ep == TELE_EP && ep_age >= 1) begin
      check_value("s_axis_tready_o", 16'(s_axis_tready_o), 16'h0000);
    end
    if (m_axis_tvalid_o && m_axis_tready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("extra byte %h came out at %0t ns with nothing expected", m_axis_tdata_o, $time);
      end else begin
        want = exp_q.pop_front();
        check_value("m_axis_tlast_o", 16'(m_axis_tlast_o), 16'(want[9]));
        check_value("m_axis_tkeep_o", 16'(m_axis_tkeep_o), 16'(want[8]));
        check_value("m_axis_tdata_o", 16'(m_axis_tdata_o), 16'(want[7:0]));
      end
    end
  endtask

  task automatic apply_row(input int r);
    int errs_before;
    int n;
    int k;
    int pkt;
    logic last_b;
    logic [9:0] entry;
    logic [15:0] rec;
    errs_before = errors;
    cur_ep = table_rows[r].ep;
    cur_rdy = table_rows[r].rdy;
    stall_en = table_rows[r].stall;
    for (k = 0; k < table_rows[r].nbytes; k++) begin
      rng = xorshift32(rng);
      last_b = k == table_rows[r].nbytes - 1;
      entry = {last_b, rng[8], rng[7:0]};
      user_q.push_back(entry);
      exp_q.push_back(entry);
    end
    if (cur_ep == TELE_EP) begin
      level_known = 1'b0;  // pops not tracked while draining
      pkt = 0;
      n = model_recs.size();
      for (k = 0; k < n; k++) begin
        rec = model_recs[k];
        pkt++;
        last_b = (k == n - 1) || (pkt == `TELE_PKT_RECORDS);
        exp_q.push_back({1'b0, 1'b1, rec[7:0]});  // low byte first
        exp_q.push_back({last_b, 1'b1, rec[15:8]});
        if (last_b) pkt = 0;
      end
      model_recs.delete();
    end
    rec = table_rows[r].base;
    for (k = 0; k < table_rows[r].nrec; k++) begin
      rec_next = rec;
      rec_pending = 1'b1;
      run_cycle();
      run_cycle();
      rec = rec + table_rows[r].step;
    end
    k = 0;
    while ((exp_q.size() > 0 || user_q.size() > 0) && k < DRAIN_LIMIT) begin
      run_cycle();
      k++;
    end
    if (exp_q.size() > 0 || user_q.size() > 0) begin
      $display("timeout in row %0d: %0d output bytes never arrived", r, exp_q.size());
      $display("Testbench failed");
      $finish;
    end
    run_cycle();  // idle cycles catch stray bytes
    run_cycle();
    if (cur_ep == TELE_EP) begin
      lvl = 0;
      level_known = 1'b1;
      check_value("has_telemetry_o", 16'(has_telemetry_o), 16'h0000);
    end
    $display("row %0d endpoint %0d: %0d records, %0d user bytes, %0d errors",
             r, cur_ep, table_rows[r].nrec, table_rows[r].nbytes, errors - errs_before);
  endtask

  initial begin
    int i;
    usb_state_i = '0;
    ctl_state_i = '0;
    blk_state_i = '0;
    crc_error_i = 1'b0;
    blk_endpt_i = 4'd1;
    blk_in_ready_i = 1'b0;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i = 1'b0;
    s_axis_tkeep_i = 1'b0;
    s_axis_tdata_i = '0;
    m_axis_tready_i = 1'b0;
    rng = 32'h0bac_d49a;
    model_last = '0;
    rec_next = '0;
    cur_ep = 4'd1;
    cur_rdy = 1'b0;
    exp_blk_ready = 1'b0;
    rec_pending = 1'b0;
    push_pending = 1'b0;
    level_known = 1'b1;
    in_fire = 1'b0;
    stall_en = 1'b0;
    lvl = 0;
    ep_age = 0;
    errors = 0;
    checks = 0;

    // endpoint, base, step, records, user bytes, stall, blk_in_ready_i
    table_rows[0] = '{4'd1, 16'h0000, 16'h0000, 0, 24, 1'b1, 1'b1};
    table_rows[1] = '{4'd1, 16'h1235, 16'h0111, 5, 6, 1'b0, 1'b0};
    table_rows[2] = '{4'd1, 16'h1679, 16'h0000, 3, 8, 1'b1, 1'b0};  // repeats the last one
    table_rows[3] = '{4'd2, 16'h0000, 16'h0000, 0, 0, 1'b1, 1'b0};
    table_rows[4] = '{4'd1, 16'h8001, 16'h0203, 20, 0, 1'b0, 1'b0};  // overfills the log
    table_rows[5] = '{4'd2, 16'h0000, 16'h0000, 0, 0, 1'b1, 1'b0};
    table_rows[6] = '{4'd1, 16'h0000, 16'h0000, 0, 10, 1'b1, 1'b1};

    i = 0;
    while (areset_n !== 1'b1 && i < 20) begin
      @(posedge clock);
      i++;
    end
    if (areset_n !== 1'b1) begin
      $display("timeout: reset never released");
      $display("Testbench failed");
      $finish;
    end
    @(negedge clock);
    check_value("m_axis_tvalid_o", 16'(m_axis_tvalid_o), 16'h0000);
    check_value("has_telemetry_o", 16'(has_telemetry_o), 16'h0000);
    check_value("blk_in_ready_o", 16'(blk_in_ready_o), 16'h0000);
    $display("reset check: %0d errors", errors);

    for (i = 0; i < NUM_ROWS; i++) begin
      apply_row(i);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
